//--- hw/neoBusPkg.sv
// CPU-side widths and the system latch address map.
// Imported by the latch and palette blocks and used in the top-level ports.

package neoBusPkg;

	//==========================================================================
	// Palette port
	//==========================================================================

	// Colour index inside one palette bank
	typedef logic [11:0] palAddr_t;

	// One palette entry as the CPU writes it
	typedef logic [15:0] palWord_t;

	//==========================================================================
	// System latch
	//==========================================================================

	// Bits 3..1 pick the latch, bit 0 is the value written into it
	typedef logic [3:0] latchAddr_t;

	// Shadow (half brightness) latch
	localparam logic [2:0] latchShadow = 3'd0;
	// Palette bank select latch
	localparam logic [2:0] latchPalBank = 3'd7;

endpackage

//--- hw/neoColorPkg.sv
// Bit layout of the NeoGeo colour word and the widths of the colour path.
// Used by the colour decoder and the video output register.

package neoColorPkg;

	// Level after the dark step, before widening
	typedef logic [5:0] level6_t;

	// Final channel value sent to the display
	typedef logic [7:0] channel_t;

	//==========================================================================
	// Colour word layout
	//==========================================================================

	// Dark bit, lowers every channel by one level
	localparam int darkBit = 15;

	// Per-channel LSBs, shared in the top nibble
	localparam int redLsbBit = 14;
	localparam int greenLsbBit = 13;
	localparam int blueLsbBit = 12;

	// Low bit of each 4-bit colour field
	localparam int redField = 8;
	localparam int greenField = 4;
	localparam int blueField = 0;

endpackage

//--- hw/clockEnables.sv
// Clock enables derived from CLK_48M.
// ce24P is the 24 MHz phase, cePixel a one-cycle pulse every pixelDivide cycles.

module clockEnables #(
	parameter int pixelDivide = 8
) (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic ce24P,
	output logic cePixel
);

	localparam int countWidth = $clog2(pixelDivide);

	// Free running divider, cleared at reset
	logic [countWidth-1:0] count;
	logic                  lastCount;

	// Pulse lands on the last count of each pixel period
	assign lastCount = (count == countWidth'(pixelDivide - 1));

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			count <= '0;
			ce24P <= 1'b0;
			cePixel <= 1'b0;
		end else begin
			if (lastCount) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
			// LSB of the counter alternates, so the 24 MHz phase follows it
			ce24P <= ~count[0];
			// First pulse on the pixelDivide-th edge after release
			cePixel <= lastCount;
		end
	end

endmodule

//--- hw/systemLatch.sv
// System latch bits used by the colour path.
// A write strobe with a 4-bit latch address sets or clears one latch bit.

module systemLatch (
	input  logic                   CLK_48M,
	input  logic                   nRESET,
	input  logic                   latchWrite,
	input  neoBusPkg::latchAddr_t  latchAddr,
	output logic                   shadow,
	output logic                   palBank
);

	import neoBusPkg::*;

	// Latch select and the bit to store
	logic [2:0] latchSel;
	logic       latchValue;

	assign latchSel = latchAddr[3:1];
	assign latchValue = latchAddr[0];

	//==========================================================================
	// Latch update
	//==========================================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWrite) begin
			case (latchSel)
				// Halves the brightness of the whole picture
				latchShadow: begin
					shadow <= latchValue;
				end
				// Switches the pixel and CPU side to the other bank
				latchPalBank: begin
					palBank <= latchValue;
				end
				// The other latches live outside this design
				default: begin
				end
			endcase
		end
	end

	// New values reach the palette and decoder from the next cycle

endmodule

//--- hw/paletteRam.sv
// Two-bank palette memory, 4096 colour words per bank.
// CPU side writes with a strobe, the pixel side reads one word per clock.

module paletteRam (
	input  logic                 CLK_48M,
	input  logic                 palWrite,
	input  neoBusPkg::palAddr_t  palAddr,
	input  neoBusPkg::palWord_t  palData,
	input  logic                 palBank,
	input  neoBusPkg::palAddr_t  pixelIndex,
	output neoBusPkg::palWord_t  palWord
);

	import neoBusPkg::*;

	// Bank bit sits above the index
	localparam int ramAddrWidth = $bits(palAddr_t) + 1;
	localparam int ramDepth = 1 << ramAddrWidth;

	palWord_t palMem [ramDepth];

	// Full memory addresses for both ports
	logic [ramAddrWidth-1:0] writeAddr;
	logic [ramAddrWidth-1:0] readAddr;

	assign writeAddr = {palBank, palAddr};
	assign readAddr = {palBank, pixelIndex};

	//==========================================================================
	// CPU write port
	//==========================================================================

	always_ff @(posedge CLK_48M) begin
		if (palWrite) begin
			palMem[writeAddr] <= palData;
		end
	end

	//==========================================================================
	// Pixel read port
	//==========================================================================

	// One cycle latency, old data on a same-edge write
	always_ff @(posedge CLK_48M) begin
		palWord <= palMem[readAddr];
	end

endmodule

//--- hw/colorDecode.sv
// Turns a palette word into 8-bit red, green and blue.
// Handles the dark bit with clamping at zero and the shadow halving.

module colorDecode (
	input  neoBusPkg::palWord_t   palWord,
	input  logic                  shadow,
	output neoColorPkg::channel_t red,
	output neoColorPkg::channel_t green,
	output neoColorPkg::channel_t blue
);

	import neoBusPkg::*;
	import neoColorPkg::*;

	// Same rule for every channel, only the bit positions differ
	function automatic channel_t decodeChannel(
		input palWord_t word,
		input int       fieldLow,
		input int       lsbPos,
		input logic     halve
	);
		logic [3:0] field;
		logic [6:0] stepped;
		level6_t    level;
		channel_t   wide;

		field = word[fieldLow +: 4];
		// Field, shared LSB, then the field MSB again; extra bit catches the borrow
		stepped = {1'b0, field, word[lsbPos], field[3]} - 7'(word[darkBit]);
		level = stepped[5:0];
		// Borrow out means the dark step went below zero
		if (stepped[6]) begin
			wide = '0;
		end else begin
			wide = {level, level[4:3]};
		end
		// Shadow drops everything to half brightness
		if (halve) begin
			wide = {1'b0, wide[7:1]};
		end
		return wide;
	endfunction

	//==========================================================================
	// Channel decode
	//==========================================================================

	always_comb begin
		red = decodeChannel(palWord, redField, redLsbBit, shadow);
		green = decodeChannel(palWord, greenField, greenLsbBit, shadow);
		blue = decodeChannel(palWord, blueField, blueLsbBit, shadow);
	end

endmodule

//--- hw/videoOut.sv
// Pixel output register, loaded once per pixel enable.
// Also lines up horizontal and vertical blank with the colour.

module videoOut (
	input  logic                  CLK_48M,
	input  logic                  nRESET,
	input  logic                  cePixel,
	input  neoColorPkg::channel_t redIn,
	input  neoColorPkg::channel_t greenIn,
	input  neoColorPkg::channel_t blueIn,
	input  logic                  chbl,
	input  logic                  nBnkb,
	output neoColorPkg::channel_t red,
	output neoColorPkg::channel_t green,
	output neoColorPkg::channel_t blue,
	output logic                  hBlank,
	output logic                  vBlank
);

	// First stage of the horizontal blank delay
	logic chblDelay;

	//==========================================================================
	// Output register
	//==========================================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			chblDelay <= 1'b0;
			hBlank <= 1'b0;
			vBlank <= 1'b0;
		end else if (cePixel) begin
			// Colour as decoded on this pixel
			red <= redIn;
			green <= greenIn;
			blue <= blueIn;
			// Horizontal blank runs two pixel enables behind
			chblDelay <= chbl;
			hBlank <= chblDelay;
			// Vertical blank comes in active low
			vBlank <= ~nBnkb;
		end
	end

endmodule

//--- hw/paletteVideoTop.sv
// Top level of the pixel output path.
// Palette RAM, system latch, colour decode and output register on CLK_48M.

module paletteVideoTop #(
	parameter int pixelDivide = 8
) (
	input  logic                  CLK_48M,
	input  logic                  nRESET,
	input  logic                  palWrite,
	input  neoBusPkg::palAddr_t   palAddr,
	input  neoBusPkg::palWord_t   palData,
	input  logic                  latchWrite,
	input  neoBusPkg::latchAddr_t latchAddr,
	input  neoBusPkg::palAddr_t   pixelIndex,
	input  logic                  chbl,
	input  logic                  nBnkb,
	output neoColorPkg::channel_t red,
	output neoColorPkg::channel_t green,
	output neoColorPkg::channel_t blue,
	output logic                  hBlank,
	output logic                  vBlank,
	output logic                  cePixel
);

	import neoBusPkg::*;
	import neoColorPkg::*;

	logic     shadow;
	logic     palBank;
	palWord_t palWord;
	channel_t redDecoded;
	channel_t greenDecoded;
	channel_t blueDecoded;

	//==========================================================================
	// Timing and control
	//==========================================================================

	// The 24 MHz phase is not needed by the colour path
	clockEnables #(
		.pixelDivide(pixelDivide)
	) u_clockEnables (
		.CLK_48M(CLK_48M), .nRESET(nRESET),
		.ce24P(), .cePixel(cePixel)
	);

	systemLatch u_systemLatch (
		.CLK_48M(CLK_48M), .nRESET(nRESET),
		.latchWrite(latchWrite), .latchAddr(latchAddr),
		.shadow(shadow), .palBank(palBank)
	);

	//==========================================================================
	// Colour path
	//==========================================================================

	paletteRam u_paletteRam (
		.CLK_48M(CLK_48M),
		.palWrite(palWrite), .palAddr(palAddr), .palData(palData),
		.palBank(palBank), .pixelIndex(pixelIndex), .palWord(palWord)
	);

	colorDecode u_colorDecode (
		.palWord(palWord), .shadow(shadow),
		.red(redDecoded), .green(greenDecoded), .blue(blueDecoded)
	);

	videoOut u_videoOut (
		.CLK_48M(CLK_48M), .nRESET(nRESET), .cePixel(cePixel),
		.redIn(redDecoded), .greenIn(greenDecoded), .blueIn(blueDecoded),
		.chbl(chbl), .nBnkb(nBnkb),
		.red(red), .green(green), .blue(blue),
		.hBlank(hBlank), .vBlank(vBlank)
	);

endmodule

//--- testbench/tbClock.sv
// Test clock and power-on reset for the palette video testbench.
// 100 ns clock period, reset held low for the first three rising edges.

module tbClock #(
	parameter int resetCycles = 3
) (
	output logic CLK_48M,
	output logic nRESET
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free running clock, 50 ns per half period
	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	// Release on a rising edge so the DUT sees a clean synchronous reset
	initial begin
		nRESET = 1'b0;
		repeat (resetCycles) @(posedge CLK_48M);
		nRESET <= 1'b1;
	end

endmodule

//--- testbench/tbPaletteVideo.sv
// Testbench for the palette video path.
// Writes palette words and latches, steps the pixel index once per pixel enable
// and checks colour, blanking and enable timing against a reference model.

module tbPaletteVideo;
	timeunit 1ns;
	timeprecision 1ps;

	import neoBusPkg::*;
	import neoColorPkg::*;

	localparam int pixelDivide = 8;
	// About 90 pixel periods of 8 cycles each, plenty of headroom
	localparam int cycleLimit = 4000;

	logic       CLK_48M;
	logic       nRESET;
	logic       palWrite;
	palAddr_t   palAddr;
	palWord_t   palData;
	logic       latchWrite;
	latchAddr_t latchAddr;
	palAddr_t   pixelIndex;
	logic       chbl;
	logic       nBnkb;
	channel_t   red;
	channel_t   green;
	channel_t   blue;
	logic       hBlank;
	logic       vBlank;
	logic       cePixel;

	//==========================================================================
	// Reference model
	//==========================================================================

	// Palette copy with the bank bit on top, plus the two latch bits
	palWord_t refPal [8192];
	logic     refShadow;
	logic     refBank;

	// Expected outputs, moved on each pixel enable
	channel_t expRed;
	channel_t expGreen;
	channel_t expBlue;
	logic     chblPrev;
	logic     expHBlank;
	logic     expVBlank;

	int       errorCount = 0;
	int       pixelCount = 0;
	int       cycleCount = 0;
	int       sinceCount = 0;
	integer   seed;
	logic [31:0] randWord;
	palAddr_t addrList [16];
	palWord_t darkList [6] = '{16'h8000, 16'hF000, 16'h0ABC, 16'h8ABC, 16'h7FFF, 16'hFFFF};

	tbClock u_tbClock (
		.CLK_48M(CLK_48M),
		.nRESET(nRESET)
	);

	paletteVideoTop #(
		.pixelDivide(pixelDivide)
	) u_paletteVideoTop (
		.CLK_48M(CLK_48M), .nRESET(nRESET),
		.palWrite(palWrite), .palAddr(palAddr), .palData(palData),
		.latchWrite(latchWrite), .latchAddr(latchAddr),
		.pixelIndex(pixelIndex), .chbl(chbl), .nBnkb(nBnkb),
		.red(red), .green(green), .blue(blue),
		.hBlank(hBlank), .vBlank(vBlank), .cePixel(cePixel)
	);

	// One channel from its field, LSB and the dark and shadow bits
	function automatic channel_t expectChannel(
		input logic [3:0] field,
		input logic       lsb,
		input logic       dark,
		input logic       shade
	);
		int       level;
		level6_t  six;
		channel_t result;

		// Field, then LSB, then the field MSB repeated at the bottom
		level = 4 * int'(field) + 2 * int'(lsb) + int'(field[3]);
		level = level - int'(dark);
		// Dark step never wraps
		if (level < 0) begin
			level = 0;
		end
		six = level6_t'(level);
		result = {six, six[4], six[3]};
		if (shade) begin
			result = result >> 1;
		end
		return result;
	endfunction

	// Prediction made on the pulse edge, while the held inputs are still valid
	always @(posedge CLK_48M) begin
		palWord_t shownWord;

		if (!nRESET) begin
			expRed <= '0;
			expGreen <= '0;
			expBlue <= '0;
			chblPrev <= 1'b0;
			expHBlank <= 1'b0;
			expVBlank <= 1'b0;
			sinceCount <= 0;
		end else if (cePixel) begin
			shownWord = refPal[{refBank, pixelIndex}];
			expRed <= expectChannel(shownWord[redField +: 4], shownWord[redLsbBit],
				shownWord[darkBit], refShadow);
			expGreen <= expectChannel(shownWord[greenField +: 4], shownWord[greenLsbBit],
				shownWord[darkBit], refShadow);
			expBlue <= expectChannel(shownWord[blueField +: 4], shownWord[blueLsbBit],
				shownWord[darkBit], refShadow);
			// hBlank lags one more pixel enable than vBlank
			chblPrev <= chbl;
			expHBlank <= chblPrev;
			expVBlank <= ~nBnkb;
			sinceCount <= 1;
			pixelCount <= pixelCount + 1;
		end else begin
			sinceCount <= sinceCount + 1;
		end
	end

	//==========================================================================
	// Checks
	//==========================================================================

	task automatic reportMismatch(input string what, input logic [7:0] got,
		input logic [7:0] want);
		errorCount = errorCount + 1;
		$display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	cePixelCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		cePixel == (sinceCount == pixelDivide))
		else reportMismatch("cePixel", {7'd0, cePixel}, {7'd0, sinceCount == pixelDivide});
	redCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET) red == expRed)
		else reportMismatch("red", red, expRed);
	greenCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET) green == expGreen)
		else reportMismatch("green", green, expGreen);
	blueCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET) blue == expBlue)
		else reportMismatch("blue", blue, expBlue);
	hBlankCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET) hBlank == expHBlank)
		else reportMismatch("hBlank", {7'd0, hBlank}, {7'd0, expHBlank});
	vBlankCheck: assert property (@(posedge CLK_48M) disable iff (!nRESET) vBlank == expVBlank)
		else reportMismatch("vBlank", {7'd0, vBlank}, {7'd0, expVBlank});

	// Watchdog
	always @(posedge CLK_48M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
			$display("Finished with errors");
			$finish;
		end
	end

	//==========================================================================
	// Stimulus
	//==========================================================================

	// Returns on the edge where the DUT captures a pixel
	task automatic waitPixel();
		@(posedge CLK_48M);
		while (!cePixel) begin
			@(posedge CLK_48M);
		end
	endtask

	task automatic showPixel(input palAddr_t index, input logic hb, input logic nvb);
		pixelIndex <= index;
		chbl <= hb;
		nBnkb <= nvb;
	endtask

	// One-cycle write strobe into the current bank
	task automatic writePalette(input palAddr_t addr, input palWord_t data);
		palWrite <= 1'b1;
		palAddr <= addr;
		palData <= data;
		refPal[{refBank, addr}] <= data;
		@(posedge CLK_48M);
		palWrite <= 1'b0;
	endtask

	task automatic writeLatch(input logic [2:0] sel, input logic value);
		latchWrite <= 1'b1;
		latchAddr <= {sel, value};
		if (sel == latchShadow) begin
			refShadow <= value;
		end else if (sel == latchPalBank) begin
			refBank <= value;
		end
		@(posedge CLK_48M);
		latchWrite <= 1'b0;
	endtask

	initial begin
		seed = 25;
		// Word 0 goes into index 0 of bank 0 while reset is held
		palWrite = 1'b1;
		palAddr = '0;
		palData = '0;
		latchWrite = 1'b0;
		latchAddr = '0;
		pixelIndex = '0;
		chbl = 1'b0;
		nBnkb = 1'b1;
		refShadow = 1'b0;
		refBank = 1'b0;
		refPal[0] = '0;
		repeat (2) @(posedge CLK_48M);
		palWrite <= 1'b0;
		wait (nRESET === 1'b1);

		// Outputs stay at zero, pulse spacing checked all along
		repeat (3) waitPixel();

		// Random words at random addresses, then read back
		for (int i = 0; i < 16; i++) begin
			randWord = $random(seed);
			addrList[i] = randWord[11:0];
			randWord = $random(seed);
			waitPixel();
			writePalette(addrList[i], randWord[15:0]);
		end
		for (int i = 0; i < 16; i++) begin
			waitPixel();
			showPixel(addrList[i], 1'b0, 1'b1);
		end

		// Dark bit cases incl. clamp at zero
		for (int i = 0; i < 6; i++) begin
			waitPixel();
			writePalette(palAddr_t'(12'h100 + i), darkList[i]);
			waitPixel();
			showPixel(palAddr_t'(12'h100 + i), 1'b0, 1'b1);
		end

		// Shadow on, same pixels again, then shadow off
		waitPixel();
		writeLatch(latchShadow, 1'b1);
		for (int i = 0; i < 4; i++) begin
			waitPixel();
			showPixel(addrList[i], 1'b0, 1'b1);
			waitPixel();
			showPixel(palAddr_t'(12'h100 + i), 1'b0, 1'b1);
		end
		waitPixel();
		writeLatch(latchShadow, 1'b0);
		waitPixel();

		// Same index in both banks
		waitPixel();
		writePalette(12'h0A5, 16'h5A3C);
		waitPixel();
		showPixel(12'h0A5, 1'b0, 1'b1);
		waitPixel();
		// Bank 1 write lands after the latch, before the next capture
		writeLatch(latchPalBank, 1'b1);
		writePalette(12'h0A5, 16'h83C5);
		waitPixel();
		waitPixel();
		writeLatch(latchPalBank, 1'b0);
		waitPixel();

		// Blank inputs toggled at random
		for (int i = 0; i < 16; i++) begin
			randWord = $random(seed);
			waitPixel();
			showPixel(12'h0A5, randWord[0], randWord[1]);
		end
		waitPixel();
		showPixel(12'h0A5, 1'b0, 1'b1);
		repeat (3) waitPixel();

		$display("Checked %0d pixels, %0d errors", pixelCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tb.f
hw/neoBusPkg.sv
hw/neoColorPkg.sv
hw/clockEnables.sv
hw/systemLatch.sv
hw/paletteRam.sv
hw/colorDecode.sv
hw/videoOut.sv
hw/paletteVideoTop.sv
testbench/tbClock.sv
testbench/tbPaletteVideo.sv

//--- run.sh
#!/bin/sh
# Build the palette video testbench with Verilator and run it.
# Pass only if the simulation output holds the pass message.

verilator --binary --timing --assert -f tb.f --top-module tbPaletteVideo \
	-o simPaletteVideo \
	&& ./obj_dir/simPaletteVideo | tee /dev/stderr | grep -q "Finished with no errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
